// ==== sim.f ====
+incdir+testbench
logic/cpuPkg.sv
logic/controlFsm.sv
logic/aluUnit.sv
logic/instrMemory.sv
logic/multiCycleCpu.sv
logic/regFile.sv
logic/dataRam.sv
logic/cpuTop.sv
testbench/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module cpuTb -o cpuTbSim \
    && ./obj_dir/cpuTbSim > sim.log 2>&1
grep -qx ">>> PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== testbench/isaModel.svh ====
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// any opcode outside the subset runs as a no-op
localparam logic [5:0] NOP_OPCODE = 6'h3f;

cpuPkg::wordT progWords [PROG_WORDS];
cpuPkg::wordT modelRegs [32];
cpuPkg::wordT modelMem [64];
cpuPkg::wordT modelPc;

function automatic logic [5:0] pickFunct();
    logic [2:0] choice;
    choice = 3'(randomBits(3));
    case (choice)
        3'd0, 3'd7: pickFunct = cpuPkg::FN_ADD;
        3'd1, 3'd6: pickFunct = cpuPkg::FN_SUB;
        3'd2: pickFunct = cpuPkg::FN_AND;
        3'd3: pickFunct = cpuPkg::FN_OR;
        default: pickFunct = cpuPkg::FN_SLT;
    endcase
endfunction

// narrow offsets make sw then lw on the same word likely
function automatic logic [15:0] memOffset();
    logic narrow;
    narrow = 1'(randomBits(1));
    if (narrow) begin
        return {11'd0, 3'(randomBits(3)), 2'b00};
    end
    return {8'd0, 6'(randomBits(6)), 2'b00};
endfunction

task automatic buildProgram();
    logic [2:0] kind;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [15:0] imm;
    logic [1:0] branchOffset;
    int reach;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
        kind = 3'(randomBits(3));
        rs = 5'(randomBits(5));
        rt = 5'(randomBits(5));
        rd = 5'(randomBits(5));
        imm = 16'(randomBits(16));
        case (kind)
            3'd0, 3'd1: progWords[i] = {cpuPkg::OP_RTYPE, rs, rt, rd, 5'd0, pickFunct()};
            3'd2, 3'd6: progWords[i] = {cpuPkg::OP_ADDI, rs, rt, imm};
            3'd3: progWords[i] = {cpuPkg::OP_LW, 5'd0, rt, memOffset()};
            3'd4: progWords[i] = {cpuPkg::OP_SW, 5'd0, rt, memOffset()};
            3'd5: begin
                // target must stay at or before the halting jump
                reach = PROG_WORDS - 2 - i;
                branchOffset = 2'(randomBits(2));
                if (int'(branchOffset) > reach) begin
                    branchOffset = 2'(reach);
                end
                progWords[i] = {cpuPkg::OP_BEQ, rs, rt, 14'd0, branchOffset};
            end
            default: progWords[i] = {NOP_OPCODE, rs, rt, imm};
        endcase
    end
    progWords[PROG_WORDS - 1] = {cpuPkg::OP_J, 26'(PROG_WORDS - 1)};
endtask

task automatic resetModel();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        modelMem[i] = '0;
    end
    modelPc = '0;
endtask

function automatic int cyclesFor(input cpuPkg::wordT word);
    case (word[31:26])
        cpuPkg::OP_RTYPE, cpuPkg::OP_ADDI, cpuPkg::OP_SW: return 4;
        cpuPkg::OP_LW: return 5;
        default: return 3;
    endcase
endfunction

task automatic writeModelReg(input logic [4:0] index, input cpuPkg::wordT value);
    if (index != 5'd0) begin
        modelRegs[index] = value;
    end
endtask

task automatic stepModel();
    cpuPkg::wordT word;
    cpuPkg::wordT opA;
    cpuPkg::wordT opB;
    cpuPkg::wordT imm;
    cpuPkg::wordT address;
    cpuPkg::wordT result;
    cpuPkg::wordT nextPc;
    word = progWords[modelPc[7:2]];
    opA = modelRegs[word[25:21]];
    opB = modelRegs[word[20:16]];
    imm = {{16{word[15]}}, word[15:0]};
    address = opA + imm;
    nextPc = modelPc + 32'd4;
    case (word[31:26])
        cpuPkg::OP_RTYPE: begin
            case (word[5:0])
                cpuPkg::FN_SUB: result = opA - opB;
                cpuPkg::FN_AND: result = opA & opB;
                cpuPkg::FN_OR: result = opA | opB;
                cpuPkg::FN_SLT: result = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                default: result = opA + opB;
            endcase
            writeModelReg(word[15:11], result);
        end
        cpuPkg::OP_ADDI: writeModelReg(word[20:16], address);
        cpuPkg::OP_LW: writeModelReg(word[20:16], modelMem[address[7:2]]);
        cpuPkg::OP_SW: modelMem[address[7:2]] = opB;
        cpuPkg::OP_BEQ: begin
            if (opA == opB) begin
                nextPc = nextPc + {imm[29:0], 2'b00};
            end
        end
        cpuPkg::OP_J: nextPc = {nextPc[31:28], word[25:0], 2'b00};
        default: ;
    endcase
    modelPc = nextPc;
endtask

`endif

// ==== testbench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    localparam int HALF_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int PROG_WORDS = 48;
    localparam int DONE_TIMEOUT = 16;
    localparam int STEP_LIMIT = 64;
    localparam int HALT_PC = (PROG_WORDS - 1) * 4;
    localparam logic [15:0] LFSR_SEED = 16'd48;

    logic cpuClk;
    logic rst;
    logic progLoad;
    cpuPkg::memIndexT progAddress;
    cpuPkg::wordT progData;
    cpuPkg::regIndexT debugRegister;
    cpuPkg::wordT debugData;
    cpuPkg::wordT pcOut;
    cpuPkg::wordT instruction;
    logic instrDone;
    logic [15:0] lfsrState;

    cpuTop UUT (
        .cpuClk(cpuClk),
        .rst(rst),
        .progLoad(progLoad),
        .progAddress(progAddress),
        .progData(progData),
        .debugRegister(debugRegister),
        .debugData(debugData),
        .pcOut(pcOut),
        .instruction(instruction),
        .instrDone(instrDone)
    );

    // taps 16 14 13 11
    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < count; k++) begin
            lfsrState = nextLfsr(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    `include "isaModel.svh"

    task automatic stopRun();
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(input string signalName, input cpuPkg::wordT actual,
                              input cpuPkg::wordT expected);
        assert (actual === expected) else begin
            $display("ERROR at %0d ns: %s is %h, expected %h",
                     $time, signalName, actual, expected);
            stopRun();
        end
    endtask

    // the current negedge counts as the first cycle
    task automatic waitForDone(output int cycles);
        cycles = 1;
        while (!instrDone && cycles < DONE_TIMEOUT) begin
            @(negedge cpuClk);
            cycles++;
        end
        assert (instrDone) else begin
            $display("instrDone never came within %0d cycles", cycles);
            stopRun();
        end
    endtask

    initial begin
        cpuClk = 1'b0;
        forever begin
            #HALF_PERIOD cpuClk = ~cpuClk;
        end
    end

    initial begin
        int cycles;
        cpuPkg::wordT currentWord;
        logic halted;
        rst = 1'b1;
        progLoad = 1'b0;
        progAddress = '0;
        progData = '0;
        debugRegister = '0;
        lfsrState = LFSR_SEED;
        halted = 1'b0;
        buildProgram();
        resetModel();

        // load port only works while rst is high
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(posedge cpuClk);
            #1;
            progLoad = 1'b1;
            progAddress = cpuPkg::memIndexT'(i);
            progData = progWords[i];
        end
        @(posedge cpuClk);
        #1;
        progLoad = 1'b0;
        repeat (RESET_CYCLES) @(posedge cpuClk);
        #1;
        rst = 1'b0;
        @(negedge cpuClk);

        for (int step = 0; step < STEP_LIMIT && !halted; step++) begin
            currentWord = progWords[modelPc[7:2]];
            waitForDone(cycles);
            checkValue("cycles per instruction", cycles, cyclesFor(currentWord));
            checkValue("instruction", instruction, currentWord);
            halted = (modelPc == HALT_PC);
            stepModel();
            @(posedge cpuClk);
            #1;
            debugRegister = cpuPkg::regIndexT'(randomBits(5));
            @(negedge cpuClk);
            checkValue("pcOut", pcOut, modelPc);
            checkValue($sformatf("debugData[x%0d]", debugRegister), debugData,
                       modelRegs[debugRegister]);
        end
        assert (halted) else begin
            $display("program never reached its halting jump");
            stopRun();
        end

        // full register dump against the model
        for (int r = 0; r < 32; r++) begin
            @(posedge cpuClk);
            #1;
            debugRegister = cpuPkg::regIndexT'(r);
            @(negedge cpuClk);
            checkValue($sformatf("debugData[x%0d]", r), debugData, modelRegs[r]);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
    input  logic cpuClk,
    input  logic rst,
    input  logic progLoad,
    input  cpuPkg::memIndexT progAddress,
    input  cpuPkg::wordT progData,
    input  cpuPkg::regIndexT debugRegister,
    output cpuPkg::wordT debugData,
    output cpuPkg::wordT pcOut,
    output cpuPkg::wordT instruction,
    output logic instrDone
);

    cpuPkg::ramReqT ramReq;
    cpuPkg::wordT ramReadData;
    cpuPkg::regIndexT readRegister1;
    cpuPkg::regIndexT readRegister2;
    cpuPkg::wordT regReadData1;
    cpuPkg::wordT regReadData2;
    cpuPkg::regWriteT regWrite;

    multiCycleCpu cpu (
        .cpuClk(cpuClk),
        .rst(rst),
        .progLoad(progLoad),
        .progAddress(progAddress),
        .progData(progData),
        .ramReq(ramReq),
        .ramReadData(ramReadData),
        .readRegister1(readRegister1),
        .readRegister2(readRegister2),
        .regReadData1(regReadData1),
        .regReadData2(regReadData2),
        .regWrite(regWrite),
        .instruction(instruction),
        .pcOut(pcOut),
        .instrDone(instrDone)
    );

    regFile registers (
        .cpuClk(cpuClk),
        .rst(rst),
        .readRegister1(readRegister1),
        .readRegister2(readRegister2),
        .readData1(regReadData1),
        .readData2(regReadData2),
        .writeReq(regWrite),
        .debugRegister(debugRegister),
        .debugData(debugData)
    );

    dataRam dataMemory (
        .cpuClk(cpuClk),
        .rst(rst),
        .request(ramReq),
        .readData(ramReadData)
    );

endmodule

// ==== logic/dataRam.sv ====
`timescale 1ns/1ps

module dataRam (
    input  logic cpuClk,
    input  logic rst,
    input  cpuPkg::ramReqT request,
    output cpuPkg::wordT readData
);

    cpuPkg::wordT mem [cpuPkg::DMEM_WORDS];
    cpuPkg::memIndexT wordIndex;

    assign wordIndex = request.address[7:2];

    always_ff @(posedge cpuClk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cpuPkg::DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (request.writeEnable) begin
            mem[wordIndex] <= request.writeData;
        end
    end

    assign readData = request.readEnable ? mem[wordIndex] : '0;

    assert property (@(posedge cpuClk) disable iff (rst)
        (request.readEnable || request.writeEnable) |-> request.address[1:0] == 2'b00);

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic cpuClk,
    input  logic rst,
    input  cpuPkg::regIndexT readRegister1,
    input  cpuPkg::regIndexT readRegister2,
    output cpuPkg::wordT readData1,
    output cpuPkg::wordT readData2,
    input  cpuPkg::regWriteT writeReq,
    input  cpuPkg::regIndexT debugRegister,
    output cpuPkg::wordT debugData
);

    cpuPkg::wordT regs [32];

    always_ff @(posedge cpuClk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeReq.writeEnable && writeReq.writeRegister != '0) begin
            regs[writeReq.writeRegister] <= writeReq.writeData;
        end
    end

    assign readData1 = regs[readRegister1];
    assign readData2 = regs[readRegister2];

    // board debug port
    assign debugData = regs[debugRegister];

    assert property (@(posedge cpuClk) disable iff (rst) regs[0] == '0);

endmodule

// ==== logic/multiCycleCpu.sv ====
`timescale 1ns/1ps

module multiCycleCpu (
    input  logic cpuClk,
    input  logic rst,
    input  logic progLoad,
    input  cpuPkg::memIndexT progAddress,
    input  cpuPkg::wordT progData,
    output cpuPkg::ramReqT ramReq,
    input  cpuPkg::wordT ramReadData,
    output cpuPkg::regIndexT readRegister1,
    output cpuPkg::regIndexT readRegister2,
    input  cpuPkg::wordT regReadData1,
    input  cpuPkg::wordT regReadData2,
    output cpuPkg::regWriteT regWrite,
    output cpuPkg::wordT instruction,
    output cpuPkg::wordT pcOut,
    output logic instrDone
);

    cpuPkg::controlT control;
    cpuPkg::wordT pc;
    cpuPkg::wordT ir;
    cpuPkg::wordT regA;
    cpuPkg::wordT regB;
    cpuPkg::wordT aluOut;
    cpuPkg::wordT mdr;
    cpuPkg::wordT fetchData;
    cpuPkg::wordT signExtImm;
    cpuPkg::wordT aluOperandB;
    cpuPkg::wordT aluResult;
    cpuPkg::wordT pcPlus4;
    cpuPkg::wordT branchTarget;
    cpuPkg::wordT jumpTarget;
    logic aluZero;

    controlFsm fsm (
        .cpuClk(cpuClk),
        .rst(rst),
        .opcode(ir[31:26]),
        .funct(ir[5:0]),
        .aluZero(aluZero),
        .control(control),
        .instrDone(instrDone)
    );

    aluUnit alu (
        .aluOp(control.aluOp),
        .operandA(regA),
        .operandB(aluOperandB),
        .result(aluResult),
        .zero(aluZero)
    );

    // loading only while the core is held in reset
    instrMemory imem (
        .cpuClk(cpuClk),
        .loadEnable(progLoad && rst),
        .loadAddress(progAddress),
        .loadData(progData),
        .fetchAddress(pc[7:2]),
        .fetchData(fetchData)
    );

    assign signExtImm = {{16{ir[15]}}, ir[15:0]};
    assign aluOperandB = control.aluSrcImm ? signExtImm : regB;
    assign pcPlus4 = pc + 32'd4;
    // pc already points past the branch here
    assign branchTarget = pc + {signExtImm[29:0], 2'b00};
    assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

    always_ff @(posedge cpuClk or posedge rst) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (control.irLoad) begin
                ir <= fetchData;
            end
            if (control.jumpTaken) begin
                pc <= jumpTarget;
            end else if (control.branchTaken) begin
                pc <= branchTarget;
            end else if (control.pcWrite) begin
                pc <= pcPlus4;
            end
        end
    end

    // operand and result latches
    always_ff @(posedge cpuClk) begin
        regA <= regReadData1;
        regB <= regReadData2;
        aluOut <= aluResult;
        if (control.memRead) begin
            mdr <= ramReadData;
        end
    end

    assign readRegister1 = ir[25:21];
    assign readRegister2 = ir[20:16];

    assign ramReq.address = aluOut;
    assign ramReq.writeData = regB;
    assign ramReq.readEnable = control.memRead;
    assign ramReq.writeEnable = control.memWrite;

    assign regWrite.writeRegister = control.writeToRt ? ir[20:16] : ir[15:11];
    assign regWrite.writeData = control.writeFromMem ? mdr : aluOut;
    assign regWrite.writeEnable = control.regWrite;

    assign instruction = ir;
    assign pcOut = pc;

    assert property (@(posedge cpuClk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// ==== logic/instrMemory.sv ====
`timescale 1ns/1ps

module instrMemory (
    input  logic cpuClk,
    input  logic loadEnable,
    input  cpuPkg::memIndexT loadAddress,
    input  cpuPkg::wordT loadData,
    input  cpuPkg::memIndexT fetchAddress,
    output cpuPkg::wordT fetchData
);

    cpuPkg::wordT mem [cpuPkg::IMEM_WORDS];

    // program stays put across reset
    always_ff @(posedge cpuClk) begin
        if (loadEnable) begin
            mem[loadAddress] <= loadData;
        end
    end

    assign fetchData = mem[fetchAddress];

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::aluOpT aluOp,
    input  cpuPkg::wordT operandA,
    input  cpuPkg::wordT operandB,
    output cpuPkg::wordT result,
    output logic zero
);

    logic signedLess;

    assign signedLess = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            cpuPkg::aluSub: result = operandA - operandB;
            cpuPkg::aluAnd: result = operandA & operandB;
            cpuPkg::aluOr:  result = operandA | operandB;
            cpuPkg::aluSlt: result = {31'd0, signedLess};
            default:        result = operandA + operandB;
        endcase
    end

    // beq compares through sub
    assign zero = (result == '0);

endmodule

// ==== logic/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
    input  logic cpuClk,
    input  logic rst,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    input  logic aluZero,
    output cpuPkg::controlT control,
    output logic instrDone
);

    cpuPkg::cpuStateT state;
    cpuPkg::cpuStateT nextState;
    cpuPkg::aluOpT functOp;
    logic isMemOp;
    logic isAluWb;

    assign isMemOp = (opcode == cpuPkg::OP_LW) || (opcode == cpuPkg::OP_SW);
    assign isAluWb = (opcode == cpuPkg::OP_RTYPE) || (opcode == cpuPkg::OP_ADDI);

    always_ff @(posedge cpuClk or posedge rst) begin
        if (rst) begin
            state <= cpuPkg::fetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            cpuPkg::fetch:   nextState = cpuPkg::decode;
            cpuPkg::decode:  nextState = cpuPkg::execute;
            cpuPkg::execute: begin
                if (isMemOp) begin
                    nextState = cpuPkg::memAccess;
                end else if (isAluWb) begin
                    nextState = cpuPkg::writeBack;
                end else begin
                    nextState = cpuPkg::fetch;
                end
            end
            cpuPkg::memAccess: begin
                nextState = (opcode == cpuPkg::OP_LW) ? cpuPkg::writeBack : cpuPkg::fetch;
            end
            default: nextState = cpuPkg::fetch;
        endcase
    end

    // unknown funct codes fall back to add
    always_comb begin
        case (funct)
            cpuPkg::FN_SUB: functOp = cpuPkg::aluSub;
            cpuPkg::FN_AND: functOp = cpuPkg::aluAnd;
            cpuPkg::FN_OR:  functOp = cpuPkg::aluOr;
            cpuPkg::FN_SLT: functOp = cpuPkg::aluSlt;
            default:        functOp = cpuPkg::aluAdd;
        endcase
    end

    always_comb begin
        control = '0;
        control.aluOp = cpuPkg::aluAdd;
        control.aluSrcImm = (opcode != cpuPkg::OP_RTYPE) && (opcode != cpuPkg::OP_BEQ);
        control.writeFromMem = (opcode == cpuPkg::OP_LW);
        control.writeToRt = (opcode != cpuPkg::OP_RTYPE);
        case (state)
            cpuPkg::fetch: begin
                control.irLoad = 1'b1;
                control.pcWrite = 1'b1;
            end
            cpuPkg::execute: begin
                if (opcode == cpuPkg::OP_RTYPE) begin
                    control.aluOp = functOp;
                end else if (opcode == cpuPkg::OP_BEQ) begin
                    control.aluOp = cpuPkg::aluSub;
                    control.branchTaken = aluZero;
                end
                control.jumpTaken = (opcode == cpuPkg::OP_J);
            end
            cpuPkg::memAccess: begin
                control.memRead = (opcode == cpuPkg::OP_LW);
                control.memWrite = (opcode == cpuPkg::OP_SW);
            end
            cpuPkg::writeBack: control.regWrite = 1'b1;
            default: ;
        endcase
    end

    // last state of every instruction class
    assign instrDone = (state == cpuPkg::writeBack)
        || (state == cpuPkg::memAccess && opcode == cpuPkg::OP_SW)
        || (state == cpuPkg::execute && !isMemOp && !isAluWb);

    assert property (@(posedge cpuClk) disable iff (rst)
        !(control.memRead && control.memWrite));

endmodule

// ==== logic/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIndexT;
    typedef logic [5:0] memIndexT;

    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 64;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI = 6'h08;
    localparam logic [5:0] OP_LW = 6'h23;
    localparam logic [5:0] OP_SW = 6'h2b;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_J = 6'h02;

    // r-type funct field
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        fetch,
        decode,
        execute,
        memAccess,
        writeBack
    } cpuStateT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    typedef struct packed {
        wordT address;
        wordT writeData;
        logic readEnable;
        logic writeEnable;
    } ramReqT;

    typedef struct packed {
        regIndexT writeRegister;
        wordT writeData;
        logic writeEnable;
    } regWriteT;

    typedef struct packed {
        logic irLoad;
        logic pcWrite;
        logic branchTaken;
        logic jumpTaken;
        aluOpT aluOp;
        logic aluSrcImm;
        logic memRead;
        logic memWrite;
        logic regWrite;
        logic writeFromMem;
        logic writeToRt;
    } controlT;

endpackage
